/* all.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_wr_if.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_lru.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/tb_clkgen.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    // pipeline side
    input  wire                       valid,
    input  wire dcache_pkg::word_t    addr,
    input  wire dcache_pkg::word_t    wdata,
    input  wire dcache_pkg::wstrb_t   wstrb,
    input  wire                       is_write,
    input  wire                       uncached,
    output logic                      ready,
    output dcache_pkg::word_t         rdata,
    output logic                      done,
    // memory side
    output logic                      mem_req,
    output logic                      mem_wr,
    output dcache_pkg::word_t         mem_addr,
    output dcache_pkg::word_t         mem_wdata,
    output dcache_pkg::wstrb_t        mem_wstrb,
    output logic [1:0]                mem_size,
    input  wire                       mem_addr_ok,
    input  wire                       mem_data_ok,
    input  wire dcache_pkg::line_t    mem_rdata,
    // arrays and replacement
    input  wire dcache_pkg::way_vec_t hit,
    input  wire dcache_pkg::line_t    rd_line0,
    input  wire dcache_pkg::line_t    rd_line1,
    input  wire                       victim,
    output logic                      use_valid,
    output logic                      use_way,
    output dcache_pkg::index_t        lru_index,
    dcache_wr_if.ctrl                 wr
);
    import dcache_pkg::*;

    localparam int IDX_LO = `DCACHE_OFFSET_W + 2;
    localparam int TAG_LO = `DCACHE_OFFSET_W + `DCACHE_INDEX_W + 2;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        accept;
    logic        hit_any;
    logic        data_ret;
    logic        fin_q;

    // request registers
    word_t       q_addr;
    word_t       q_wdata;
    wstrb_t      q_wstrb;
    logic        q_is_write;
    logic        q_uncached;

    tag_t        q_tag;
    index_t      q_index;
    offset_t     q_offset;

    line_t       hit_line;
    word_t       hit_word;
    word_t       resp_q;

    assign ready    = (state == IDLE);
    assign accept   = valid && ready;
    assign hit_any  = |hit;
    assign data_ret = mem_data_ok && !fin_q && (state inside {MISS_WAIT, WR_WAIT, UC_WAIT});

    //////////////////////////////////////////////////////////////////////
    // request latch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            q_addr  <= addr;
            q_wdata <= wdata;
            q_wstrb <= wstrb;
        end
    end

    assign q_tag    = q_addr[31:TAG_LO];
    assign q_index  = q_addr[TAG_LO-1:IDX_LO];
    assign q_offset = q_addr[IDX_LO-1:2];

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            fin_q      <= 1'b0;
            q_is_write <= 1'b0;
            q_uncached <= 1'b0;
        end else begin
            state <= state_nxt;
            // one cycle between data_ok and done
            fin_q <= data_ret;
            if (accept) begin
                q_is_write <= is_write;
                q_uncached <= uncached;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = uncached ? UC_REQ : LOOKUP;
                end
            end
            LOOKUP: begin
                if (q_is_write) begin
                    state_nxt = WR_REQ;
                end else if (hit_any) begin
                    state_nxt = IDLE;
                end else begin
                    state_nxt = MISS_REQ;
                end
            end
            MISS_REQ: begin
                if (mem_addr_ok) begin
                    state_nxt = MISS_WAIT;
                end
            end
            WR_REQ: begin
                if (mem_addr_ok) begin
                    state_nxt = WR_WAIT;
                end
            end
            UC_REQ: begin
                if (mem_addr_ok) begin
                    state_nxt = UC_WAIT;
                end
            end
            MISS_WAIT, WR_WAIT, UC_WAIT: begin
                if (fin_q) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // array and lru updates
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        wr.tag_we  = '0;
        wr.data_we = '0;
        wr.refill  = 1'b0;
        use_valid  = 1'b0;
        use_way    = 1'b0;
        if (state == LOOKUP && hit_any) begin
            // store hit merges bytes, any hit refreshes the lru bit
            wr.data_we = q_is_write ? hit : '0;
            use_valid  = 1'b1;
            use_way    = hit[1];
        end else if (state == MISS_WAIT && data_ret) begin
            wr.tag_we  = {victim, ~victim};
            wr.data_we = {victim, ~victim};
            wr.refill  = 1'b1;
            use_valid  = 1'b1;
            use_way    = victim;
        end
    end

    assign wr.tag    = q_tag;
    assign wr.index  = q_index;
    assign wr.offset = q_offset;
    assign wr.wstrb  = q_wstrb;
    assign wr.wdata  = q_wdata;
    assign lru_index = q_index;

    //////////////////////////////////////////////////////////////////////
    // read data return
    //////////////////////////////////////////////////////////////////////

    assign hit_line = hit[1] ? rd_line1 : rd_line0;
    assign hit_word = hit_line[{q_offset, 5'd0} +: 32];

    // uncached word sits in the low word of the bus
    always_ff @(posedge clk) begin
        if (data_ret) begin
            resp_q <= q_uncached ? mem_rdata[31:0] : mem_rdata[{q_offset, 5'd0} +: 32];
        end
    end

    assign rdata = fin_q ? resp_q : hit_word;
    assign done  = fin_q || (state == LOOKUP && !q_is_write && hit_any);

    //////////////////////////////////////////////////////////////////////
    // memory bus
    //////////////////////////////////////////////////////////////////////

    assign mem_req   = (state inside {MISS_REQ, WR_REQ, UC_REQ});
    assign mem_wr    = q_is_write;
    // cached reads are always line refills
    assign mem_addr  = (q_is_write || q_uncached) ? q_addr
                                                  : {q_addr[31:IDX_LO], {IDX_LO{1'b0}}};
    assign mem_size  = (q_is_write || q_uncached) ? 2'd2 : 2'd3;
    assign mem_wdata = q_wdata;
    assign mem_wstrb = q_is_write ? q_wstrb : '0;

endmodule

`default_nettype wire

/* hdl/dcache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_data_array (
    input  wire                     clk,
    input  wire dcache_pkg::index_t rd_index,
    dcache_wr_if.data_side          wr,
    input  wire dcache_pkg::line_t  refill_line,
    output dcache_pkg::line_t       rd_line0,
    output dcache_pkg::line_t       rd_line1
);
    import dcache_pkg::*;

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    line_t line_mem [2][SETS];

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr.data_we[w]) begin
                if (wr.refill) begin
                    // whole line from memory
                    line_mem[w][wr.index] <= refill_line;
                end else begin
                    // store hit, only the enabled bytes
                    for (int b = 0; b < 4; b++) begin
                        if (wr.wstrb[b]) begin
                            line_mem[w][wr.index][32 * int'(wr.offset) + 8 * b +: 8]
                                <= wr.wdata[8 * b +: 8];
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////

    // both ways read together, ctrl picks one on hit
    always_ff @(posedge clk) begin
        rd_line0 <= line_mem[0][rd_index];
        rd_line1 <= line_mem[1][rd_index];
    end

endmodule

`default_nettype wire

/* hdl/dcache_lru.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_lru (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire dcache_pkg::index_t index,
    input  wire                     use_valid,
    input  wire                     use_way,
    output logic                    victim
);
    localparam int SETS = 1 << `DCACHE_INDEX_W;

    // each bit names the way to replace next
    logic [SETS-1:0] lru_bits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (use_valid) begin
            lru_bits[index] <= ~use_way;
        end
    end

    assign victim = lru_bits[index];

endmodule

`default_nettype wire

/* hdl/dcache_pkg.sv */
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

    // data and address words
    typedef logic [31:0]                  word_t;
    typedef logic [`DCACHE_LINE_W-1:0]    line_t;

    // address fields
    typedef logic [`DCACHE_TAG_W-1:0]     tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]   index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0]  offset_t;

    typedef logic [3:0]                   wstrb_t;

    // one bit per way
    typedef logic [1:0]                   way_vec_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        WR_REQ,
        WR_WAIT,
        UC_REQ,
        UC_WAIT
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// set index bits, 16 sets per way
`define DCACHE_INDEX_W 4

// word-in-line bits, four words per line
`define DCACHE_OFFSET_W 2

// tag covers what is left of the word address
`define DCACHE_TAG_W (30 - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

// line width in bits
`define DCACHE_LINE_W (32 * (1 << `DCACHE_OFFSET_W))

`endif

/* hdl/dcache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_tag_array (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire dcache_pkg::index_t rd_index,
    dcache_wr_if.tag_side           wr,
    output dcache_pkg::way_vec_t    hit
);
    import dcache_pkg::*;

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    tag_t     tag_mem [2][SETS];
    way_vec_t valid [SETS];

    // registered read side
    tag_t     rd_tag [2];
    way_vec_t rd_valid;

    //////////////////////////////////////////////////////////////////////
    // tag storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr.tag_we[w]) begin
                tag_mem[w][wr.index] <= wr.tag;
            end
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= '0;
            end
            rd_valid <= '0;
        end else begin
            // a tag write always brings in a fresh line
            if (|wr.tag_we) begin
                valid[wr.index] <= valid[wr.index] | wr.tag_we;
            end
            rd_valid <= valid[rd_index];
        end
    end

    // compare against the tag latched with the request
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = rd_valid[w] && (rd_tag[w] == wr.tag);
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_top (
    input  wire                     clk,
    input  wire                     rst_n,
    // pipeline side
    input  wire                     valid,
    input  wire dcache_pkg::word_t  addr,
    input  wire dcache_pkg::word_t  wdata,
    input  wire dcache_pkg::wstrb_t wstrb,
    input  wire                     is_write,
    input  wire                     uncached,
    output logic                    ready,
    output dcache_pkg::word_t       rdata,
    output logic                    done,
    // memory side
    output logic                    mem_req,
    output logic                    mem_wr,
    output dcache_pkg::word_t       mem_addr,
    output dcache_pkg::word_t       mem_wdata,
    output dcache_pkg::wstrb_t      mem_wstrb,
    output logic [1:0]              mem_size,
    input  wire                     mem_addr_ok,
    input  wire                     mem_data_ok,
    input  wire dcache_pkg::line_t  mem_rdata
);
    import dcache_pkg::*;

    localparam int IDX_LO = `DCACHE_OFFSET_W + 2;

    index_t   rd_index;
    way_vec_t hit;
    line_t    rd_line0;
    line_t    rd_line1;
    logic     victim;
    logic     use_valid;
    logic     use_way;
    index_t   lru_index;

    dcache_wr_if wr_if ();

    // arrays start reading in the acceptance cycle
    assign rd_index = addr[IDX_LO + `DCACHE_INDEX_W - 1:IDX_LO];

    dcache_ctrl ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .addr        (addr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .is_write    (is_write),
        .uncached    (uncached),
        .ready       (ready),
        .rdata       (rdata),
        .done        (done),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_size    (mem_size),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata),
        .hit         (hit),
        .rd_line0    (rd_line0),
        .rd_line1    (rd_line1),
        .victim      (victim),
        .use_valid   (use_valid),
        .use_way     (use_way),
        .lru_index   (lru_index),
        .wr          (wr_if.ctrl)
    );

    dcache_tag_array tag_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (rd_index),
        .wr       (wr_if.tag_side),
        .hit      (hit)
    );

    dcache_data_array data_i (
        .clk         (clk),
        .rd_index    (rd_index),
        .wr          (wr_if.data_side),
        .refill_line (mem_rdata),
        .rd_line0    (rd_line0),
        .rd_line1    (rd_line1)
    );

    dcache_lru lru_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (lru_index),
        .use_valid (use_valid),
        .use_way   (use_way),
        .victim    (victim)
    );

endmodule

`default_nettype wire

/* hdl/dcache_wr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dcache_wr_if;
    import dcache_pkg::*;

    // latched request fields
    tag_t     tag;
    index_t   index;
    offset_t  offset;
    wstrb_t   wstrb;
    word_t    wdata;

    // array write controls
    way_vec_t tag_we;
    way_vec_t data_we;
    logic     refill;

    modport ctrl (output tag, index, offset, wstrb, wdata, tag_we, data_we, refill);
    modport tag_side (input tag, index, tag_we);
    modport data_side (input index, offset, wstrb, wdata, data_we, refill);

endinterface

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module dcache_tb -o dcache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/dcache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

/* tb/dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     valid,
    input wire                     ready,
    input wire                     done,
    input wire                     mem_req,
    input wire                     mem_wr,
    input wire dcache_pkg::word_t  mem_addr,
    input wire dcache_pkg::word_t  mem_wdata,
    input wire dcache_pkg::wstrb_t mem_wstrb,
    input wire [1:0]               mem_size,
    input wire                     mem_addr_ok
);

    // request fields frozen until the address is taken
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_addr_ok) |=> (mem_req && $stable(mem_addr) && $stable(mem_wr)
            && $stable(mem_size) && $stable(mem_wdata) && $stable(mem_wstrb)))
        else $error("mem_req dropped or request changed before mem_addr_ok");

    req_drops: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && mem_addr_ok) |=> !mem_req)
        else $error("mem_req still high after mem_addr_ok");

    done_not_accept: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && valid && ready))
        else $error("done seen in an accepting cycle");

    busy_on_bus: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> !ready)
        else $error("ready high while mem_req is pending");

endmodule

`default_nettype wire

/* tb/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int SETS       = 1 << `DCACHE_INDEX_W;
    localparam int WORDS      = 1 << `DCACHE_OFFSET_W;
    localparam int MEM_AW     = 10;
    localparam int MEM_WORDS  = 1 << MEM_AW;
    localparam int MAX_CYCLES = 20000;

    logic       clk;
    logic       rst_n;
    logic       valid;
    word_t      addr;
    word_t      wdata;
    wstrb_t     wstrb;
    logic       is_write;
    logic       uncached;
    logic       ready;
    word_t      rdata;
    logic       done;
    logic       mem_req;
    logic       mem_wr;
    word_t      mem_addr;
    word_t      mem_wdata;
    wstrb_t     mem_wstrb;
    logic [1:0] mem_size;
    logic       mem_addr_ok;
    logic       mem_data_ok;
    line_t      mem_rdata;

    // memory model and its request log
    word_t      mem [MEM_WORDS];
    int         line_reqs;
    int         word_reqs;
    word_t      last_addr;
    logic       last_wr;
    logic [1:0] last_size;
    word_t      last_wdata;
    wstrb_t     last_wstrb;

    // reference model of memory and cache contents
    word_t      ref_mem [MEM_WORDS];
    tag_t       ref_tag [2][SETS];
    logic       ref_valid [2][SETS];
    logic       ref_lru [SETS];
    word_t      ref_data [2][SETS][WORDS];

    int         cycles = 0;
    string      test_name = "reset";

    tb_clkgen clkgen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dcache_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .addr        (addr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .is_write    (is_write),
        .uncached    (uncached),
        .ready       (ready),
        .rdata       (rdata),
        .done        (done),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_size    (mem_size),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    bind dcache_top dcache_checker checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .ready       (ready),
        .done        (done),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_size    (mem_size),
        .mem_addr_ok (mem_addr_ok)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic word_t fill_word(input int i);
        return 32'h5a5a_0000 ^ {i[9:0], 12'h000, i[9:0]};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t d, input wstrb_t s);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[8 * b +: 8] = d[8 * b +: 8];
            end
        end
        return r;
    endfunction

    task automatic check(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles, stuck in %s", MAX_CYCLES, test_name);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////////////////////////

    task automatic serve_memory();
        int delay;
        int idx;
        int base;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                last_addr  = mem_addr;
                last_wr    = mem_wr;
                last_size  = mem_size;
                last_wdata = mem_wdata;
                last_wstrb = mem_wstrb;
                idx        = int'(mem_addr[2 +: MEM_AW]);
                base       = (idx / WORDS) * WORDS;
                delay      = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                mem_addr_ok = 1'b1;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                mem_rdata   = '0;
                if (last_wr) begin
                    mem[idx] = merge_bytes(mem[idx], last_wdata, last_wstrb);
                    word_reqs++;
                end else if (last_size == 2'd3) begin
                    for (int k = 0; k < WORDS; k++) begin
                        mem_rdata[32 * k +: 32] = mem[base + k];
                    end
                    line_reqs++;
                end else begin
                    mem_rdata[31:0] = mem[idx];
                    word_reqs++;
                end
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    endtask

    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        line_reqs   = 0;
        word_reqs   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        wait (rst_n === 1'b1);
        serve_memory();
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and request driver
    //////////////////////////////////////////////////////////////////////

    // returns the expected read word and whether a line refill follows
    task automatic predict(input word_t a, input logic w, input logic u, input word_t d,
                           input wstrb_t s, output word_t exp_rd, output logic exp_line);
        index_t set;
        tag_t   tag;
        int     off;
        int     idx;
        int     way;
        set      = a[`DCACHE_OFFSET_W + 2 +: `DCACHE_INDEX_W];
        tag      = a[31:`DCACHE_OFFSET_W + `DCACHE_INDEX_W + 2];
        off      = int'(a[2 +: `DCACHE_OFFSET_W]);
        idx      = int'(a[2 +: MEM_AW]);
        way      = -1;
        exp_rd   = '0;
        exp_line = 1'b0;
        for (int v = 0; v < 2; v++) begin
            if (!u && ref_valid[v][set] && ref_tag[v][set] == tag) begin
                way = v;
            end
        end
        if (w) begin
            ref_mem[idx] = merge_bytes(ref_mem[idx], d, s);
            if (way >= 0) begin
                ref_data[way][set][off] = merge_bytes(ref_data[way][set][off], d, s);
                ref_lru[set] = (way == 0);
            end
        end else if (u) begin
            exp_rd = ref_mem[idx];
        end else if (way >= 0) begin
            exp_rd = ref_data[way][set][off];
            ref_lru[set] = (way == 0);
        end else begin
            // refill into the least recently used way
            way = int'(ref_lru[set]);
            ref_valid[way][set] = 1'b1;
            ref_tag[way][set]   = tag;
            for (int k = 0; k < WORDS; k++) begin
                ref_data[way][set][k] = ref_mem[idx - off + k];
            end
            ref_lru[set] = (way == 0);
            exp_rd   = ref_data[way][set][off];
            exp_line = 1'b1;
        end
    endtask

    task automatic access(input word_t a, input logic w, input logic u, input word_t d,
                          input wstrb_t s, output word_t rd, output int lat);
        word_t exp_rd;
        logic  exp_line;
        int    lines0;
        int    words0;
        predict(a, w, u, d, s, exp_rd, exp_line);
        lines0   = line_reqs;
        words0   = word_reqs;
        valid    = 1'b1;
        addr     = a;
        is_write = w;
        uncached = u;
        wdata    = d;
        wstrb    = s;
        while (!ready) @(negedge clk);
        @(negedge clk);
        valid = 1'b0;
        lat   = 1;
        while (!done) begin
            @(negedge clk);
            lat++;
        end
        rd = rdata;
        @(negedge clk);
        if (!w) begin
            check("read data", exp_rd, rd);
        end
        check("line request count", lines0 + int'(exp_line), line_reqs);
        check("word request count", words0 + ((w || u) ? 1 : 0), word_reqs);
        if (exp_line) begin
            check("line address", a & ~word_t'(WORDS * 4 - 1), last_addr);
            check("line size", 32'd3, {30'd0, last_size});
        end else if (w || u) begin
            check("word address", a, last_addr);
            check("word size", 32'd2, {30'd0, last_size});
            check("write flag", {31'd0, w}, {31'd0, last_wr});
        end
        if (w) begin
            check("write data", d, last_wdata);
            check("write strobes", {28'd0, s}, {28'd0, last_wstrb});
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_read_hit();
        word_t rd;
        int    lat;
        int    lines0;
        test_name = "read_hit";
        lines0 = line_reqs;
        access(32'h120, 1'b0, 1'b0, '0, '0, rd, lat);
        check("miss word", fill_word(32'h120 >> 2), rd);
        check("lines after miss", lines0 + 1, line_reqs);
        access(32'h128, 1'b0, 1'b0, '0, '0, rd, lat);
        check("hit word", fill_word(32'h128 >> 2), rd);
        check("hit latency", 1, lat);
        check("lines after hit", lines0 + 1, line_reqs);
    endtask

    task automatic test_write_hit();
        word_t old;
        word_t rd;
        int    lat;
        int    lines0;
        test_name = "write_hit";
        access(32'h124, 1'b0, 1'b0, '0, '0, old, lat);
        check("hit latency", 1, lat);
        lines0 = line_reqs;
        access(32'h124, 1'b1, 1'b0, 32'haabbccdd, 4'b0101, rd, lat);
        access(32'h124, 1'b0, 1'b0, '0, '0, rd, lat);
        check("merged word", {old[31:24], 8'hbb, old[15:8], 8'hdd}, rd);
        check("no refill", lines0, line_reqs);
    endtask

    task automatic test_write_miss();
        word_t rd;
        int    lat;
        int    lines0;
        test_name = "write_miss";
        lines0 = line_reqs;
        access(32'h244, 1'b1, 1'b0, 32'h01020304, 4'hf, rd, lat);
        check("memory word", 32'h01020304, mem[32'h244 >> 2]);
        check("no allocation", lines0, line_reqs);
        access(32'h244, 1'b0, 1'b0, '0, '0, rd, lat);
        check("refill after write", lines0 + 1, line_reqs);
        check("read back", 32'h01020304, rd);
    endtask

    // three tags in set 6
    task automatic test_lru();
        word_t rd;
        int    lat;
        int    lines0;
        test_name = "lru";
        lines0 = line_reqs;
        access(32'h060, 1'b0, 1'b0, '0, '0, rd, lat);
        access(32'h160, 1'b0, 1'b0, '0, '0, rd, lat);
        access(32'h060, 1'b0, 1'b0, '0, '0, rd, lat);
        access(32'h260, 1'b0, 1'b0, '0, '0, rd, lat);
        check("lines after A B A C", lines0 + 3, line_reqs);
        access(32'h064, 1'b0, 1'b0, '0, '0, rd, lat);
        check("A still cached", lines0 + 3, line_reqs);
        access(32'h168, 1'b0, 1'b0, '0, '0, rd, lat);
        check("B was evicted", lines0 + 4, line_reqs);
    endtask

    task automatic test_uncached();
        word_t old;
        word_t rd;
        int    lat;
        int    lines0;
        test_name = "uncached";
        lines0 = line_reqs;
        access(32'h12c, 1'b0, 1'b1, '0, '0, rd, lat);
        check("uncached address", 32'h12c, last_addr);
        check("uncached size", 32'd2, {30'd0, last_size});
        check("no refill", lines0, line_reqs);
        access(32'h128, 1'b0, 1'b0, '0, '0, old, lat);
        access(32'h128, 1'b1, 1'b1, 32'h11223344, 4'hf, rd, lat);
        check("memory word", 32'h11223344, mem[32'h128 >> 2]);
        access(32'h128, 1'b0, 1'b0, '0, '0, rd, lat);
        check("cached copy kept", old, rd);
        access(32'h128, 1'b0, 1'b1, '0, '0, rd, lat);
        check("uncached read", 32'h11223344, rd);
    endtask

    task automatic test_random_mix();
        word_t  a;
        logic   w;
        logic   u;
        word_t  d;
        wstrb_t s;
        word_t  rd;
        int     lat;
        test_name = "random_mix";
        for (int n = 0; n < 300; n++) begin
            a = ($urandom_range(2, 0) << 8) | ($urandom_range(3, 0) << 4)
                | ($urandom_range(3, 0) << 2);
            w = ($urandom_range(9, 0) < 3);
            u = ($urandom_range(9, 0) == 0);
            d = $urandom;
            s = wstrb_t'($urandom_range(15, 1));
            access(a, w, u, d, s, rd, lat);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check("final memory", ref_mem[i], mem[i]);
        end
    endtask

    initial begin
        void'($urandom(87011));
        valid    = 1'b0;
        addr     = '0;
        wdata    = '0;
        wstrb    = '0;
        is_write = 1'b0;
        uncached = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end
        for (int s = 0; s < SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int v = 0; v < 2; v++) begin
                ref_valid[v][s] = 1'b0;
                ref_tag[v][s]   = '0;
            end
        end
        wait (rst_n === 1'b1);
        @(negedge clk);
        check("ready after reset", 32'd1, {31'd0, ready});
        test_read_hit();
        test_write_hit();
        test_write_miss();
        test_lru();
        test_uncached();
        test_random_mix();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
